/* logic/rx_pkg.sv */
// shared widths, types and constants for the uDMA linear receive path, imported by every RTL block
package rx_pkg;

    ////////////////////
    // sizes
    ////////////////////
    localparam int N_CH        = 4;
    localparam int L2_AW       = 16;    // byte address inside the L2 window
    localparam int TRANS_W     = 16;
    localparam int DATA_W      = 32;
    localparam int BE_W        = DATA_W / 8;
    localparam int ALIGN_BITS  = $clog2(BE_W);
    localparam int CH_IDX_W    = $clog2(N_CH);
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    // upper address bits put in front of every L2 write
    localparam logic [31-L2_AW:0] L2_BASE = 16'h1C00;

    ////////////////////
    // types
    ////////////////////
    typedef logic [L2_AW-1:0]    l2_addr_t;
    typedef logic [TRANS_W-1:0]  trans_size_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [BE_W-1:0]     be_t;
    typedef logic [CH_IDX_W-1:0] ch_idx_t;
    typedef logic [QPTR_W-1:0]   qptr_t;
    typedef logic [QCNT_W-1:0]   qcnt_t;

    typedef enum logic [1:0] {
        DS_BYTE = 2'd0,
        DS_HALF = 2'd1,
        DS_WORD = 2'd2
    } datasize_e;

    typedef enum logic {
        ST_ALIGNED = 1'b0,
        ST_SECOND  = 1'b1   // writing the bytes that spilled into the next word
    } split_state_e;

endpackage

/* logic/rx_ch_if.sv */
// beat request from one linear channel to the sampling stage, one instance per channel
`timescale 1ns/1ps

interface rx_ch_if;
    import rx_pkg::*;

    logic      req;     // peripheral valid qualified by the channel enable
    logic      ready;
    l2_addr_t  addr;
    data_t     data;
    datasize_e size;

    modport channel
    (
        output req, addr, data, size,
        input  ready
    );

    modport sampler
    (
        input  req, addr, data, size,
        output ready
    );

endinterface

/* logic/l2_wr_if.sv */
// valid/ready beat link used between the sampler, the write queue and the L2 aligner
`timescale 1ns/1ps

interface l2_wr_if;
    import rx_pkg::*;

    logic      valid;
    logic      ready;
    l2_addr_t  addr;
    data_t     data;
    datasize_e size;

    modport source
    (
        output valid, addr, data, size,
        input  ready
    );

    modport sink
    (
        input  valid, addr, data, size,
        output ready
    );

endinterface

/* logic/rx_lin_channel.sv */
// address generator of one linear receive channel, instantiated once per channel in the top level
`timescale 1ns/1ps

module rx_lin_channel
(
    input  logic                clk_i,
    input  logic                rstn_i,
    input  rx_pkg::l2_addr_t    cfg_startaddr_i,
    input  rx_pkg::trans_size_t cfg_size_i,
    input  logic                cfg_continuous_i,
    input  logic                cfg_en_i,
    input  logic                cfg_clr_i,
    input  logic                periph_valid_i,
    input  rx_pkg::data_t       periph_data_i,
    input  rx_pkg::datasize_e   periph_size_i,
    output logic                periph_ready_o,
    output logic                ch_en_o,
    output logic                event_o,
    rx_ch_if.channel            ch
);
    import rx_pkg::*;

    l2_addr_t    r_addr;
    trans_size_t r_left;
    logic        r_en;
    logic        r_event;
    trans_size_t s_beat_bytes;
    logic        s_accept;
    logic        s_last;

    assign ch.req         = periph_valid_i & r_en;
    assign ch.addr        = r_addr;
    assign ch.data        = periph_data_i;
    assign ch.size        = periph_size_i;
    assign periph_ready_o = ch.ready;
    assign ch_en_o        = r_en;
    assign event_o        = r_event;

    assign s_accept = ch.req & ch.ready;
    assign s_last   = (r_left <= s_beat_bytes);   // this beat uses up the transfer

    always_comb
    begin
        case (periph_size_i)
            DS_BYTE: s_beat_bytes = trans_size_t'(1);
            DS_HALF: s_beat_bytes = trans_size_t'(2);
            default: s_beat_bytes = trans_size_t'(4);
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_addr  <= '0;
            r_left  <= '0;
            r_en    <= 1'b0;
            r_event <= 1'b0;
        end
        else
        begin
            r_event <= 1'b0;
            if (cfg_clr_i)
            begin
                r_en <= 1'b0;   // abort without an event
            end
            else if (cfg_en_i)
            begin
                r_addr <= cfg_startaddr_i;
                r_left <= cfg_size_i;
                r_en   <= 1'b1;
            end
            else if (s_accept)
            begin
                if (s_last)
                begin
                    r_event <= 1'b1;
                    if (cfg_continuous_i)
                    begin
                        r_addr <= cfg_startaddr_i;
                        r_left <= cfg_size_i;
                    end
                    else
                        r_en <= 1'b0;
                end
                else
                begin
                    r_addr <= r_addr + l2_addr_t'(s_beat_bytes);
                    r_left <= r_left - s_beat_bytes;
                end
            end
        end
    end

endmodule

/* logic/rx_rr_arbiter.sv */
// round-robin arbiter over the channel requests, used by the sampling stage
`timescale 1ns/1ps

module rx_rr_arbiter
(
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic [rx_pkg::N_CH-1:0] req_i,
    input  logic                    ack_i,
    output logic [rx_pkg::N_CH-1:0] grant_o,
    output rx_pkg::ch_idx_t         grant_idx_o,
    output logic                    any_grant_o
);
    import rx_pkg::*;

    ch_idx_t r_last;    // channel served most recently

    always_comb
    begin : pick
        ch_idx_t cand;
        logic    found;
        found       = 1'b0;
        grant_idx_o = '0;
        for (int i = 1; i <= N_CH; i++)
        begin
            cand = ch_idx_t'((int'(r_last) + i) % N_CH);
            if (!found && req_i[cand])
            begin
                found       = 1'b1;
                grant_idx_o = cand;
            end
        end
        any_grant_o = found;
        grant_o     = '0;
        grant_o[grant_idx_o] = found;
    end

    // priority only rotates once the granted beat has been taken
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_last <= ch_idx_t'(N_CH - 1);  // channel 0 goes first
        else if (ack_i && any_grant_o)
            r_last <= grant_idx_o;
    end

endmodule

/* logic/rx_sample_stage.sv */
// picks the granted channel, registers its beat and pushes it into the write queue
`timescale 1ns/1ps

module rx_sample_stage
(
    input  logic       clk_i,
    input  logic       rstn_i,
    rx_ch_if.sampler   ch [rx_pkg::N_CH],
    l2_wr_if.source    q
);
    import rx_pkg::*;

    logic [N_CH-1:0] s_req;
    logic [N_CH-1:0] s_grant;
    ch_idx_t         s_grant_idx;
    logic            s_any_grant;
    logic            s_take;
    l2_addr_t        s_ch_addr [N_CH];
    data_t           s_ch_data [N_CH];
    datasize_e       s_ch_size [N_CH];

    logic            r_valid;
    l2_addr_t        r_addr;
    data_t           r_data;
    datasize_e       r_size;

    // the register can only take a beat while the queue has room
    assign s_take = q.ready;

    for (genvar g = 0; g < N_CH; g++)
    begin : g_ch
        assign s_req[g]     = ch[g].req;
        assign s_ch_addr[g] = ch[g].addr;
        assign s_ch_data[g] = ch[g].data;
        assign s_ch_size[g] = ch[g].size;
        assign ch[g].ready  = s_grant[g] & s_take;
    end

    rx_rr_arbiter u_arbiter
    (
        .clk_i       ( clk_i       ),
        .rstn_i      ( rstn_i      ),
        .req_i       ( s_req       ),
        .ack_i       ( s_take      ),
        .grant_o     ( s_grant     ),
        .grant_idx_o ( s_grant_idx ),
        .any_grant_o ( s_any_grant )
    );

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_valid <= 1'b0;
        else if (s_take)
            r_valid <= s_any_grant; // old beat drains as the new one lands
    end

    always_ff @(posedge clk_i)
    begin
        if (s_take && s_any_grant)
        begin
            r_addr <= s_ch_addr[s_grant_idx];
            r_data <= s_ch_data[s_grant_idx];
            r_size <= s_ch_size[s_grant_idx];
        end
    end

    assign q.valid = r_valid;
    assign q.addr  = r_addr;
    assign q.data  = r_data;
    assign q.size  = r_size;

endmodule

/* logic/rx_wr_queue.sv */
// small FIFO holding registered beats until the L2 aligner has written them
`timescale 1ns/1ps

module rx_wr_queue
(
    input  logic    clk_i,
    input  logic    rstn_i,
    l2_wr_if.sink   push,
    l2_wr_if.source pop
);
    import rx_pkg::*;

    l2_addr_t  mem_addr [QUEUE_DEPTH];
    data_t     mem_data [QUEUE_DEPTH];
    datasize_e mem_size [QUEUE_DEPTH];

    qptr_t r_wr_ptr;
    qptr_t r_rd_ptr;
    qcnt_t r_count;
    logic  s_push;
    logic  s_pop;

    assign push.ready = (r_count != qcnt_t'(QUEUE_DEPTH));
    assign pop.valid  = (r_count != '0);
    assign s_push     = push.valid & push.ready;
    assign s_pop      = pop.valid & pop.ready;

    assign pop.addr = mem_addr[r_rd_ptr];
    assign pop.data = mem_data[r_rd_ptr];
    assign pop.size = mem_size[r_rd_ptr];

    always_ff @(posedge clk_i)
    begin
        if (s_push)
        begin
            mem_addr[r_wr_ptr] <= push.addr;
            mem_data[r_wr_ptr] <= push.data;
            mem_size[r_wr_ptr] <= push.size;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end
        else
        begin
            if (s_push)
                r_wr_ptr <= (r_wr_ptr == qptr_t'(QUEUE_DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
            if (s_pop)
                r_rd_ptr <= (r_rd_ptr == qptr_t'(QUEUE_DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
            if (s_push && !s_pop)
                r_count <= r_count + 1'b1;
            else if (s_pop && !s_push)
                r_count <= r_count - 1'b1;
        end
    end

endmodule

/* logic/rx_l2_aligner.sv */
// turns each queued beat into one or two aligned 32-bit writes on the L2 port
`timescale 1ns/1ps

module rx_l2_aligner
(
    input  logic          clk_i,
    input  logic          rstn_i,
    l2_wr_if.sink         beat,
    output logic          l2_req_o,
    input  logic          l2_gnt_i,
    output logic [31:0]   l2_addr_o,
    output rx_pkg::be_t   l2_be_o,
    output rx_pkg::data_t l2_wdata_o
);
    import rx_pkg::*;

    split_state_e        r_state;
    split_state_e        s_state_next;
    be_t                 s_base_be;
    data_t               s_data_masked;
    logic [2*BE_W-1:0]   s_be_wide;
    logic [2*DATA_W-1:0] s_data_wide;
    logic                s_cross;
    l2_addr_t            s_word_addr;
    l2_addr_t            s_word_addr_next;

    always_comb
    begin
        case (beat.size)
            DS_BYTE:
            begin
                s_base_be     = be_t'(4'b0001);
                s_data_masked = {24'h0, beat.data[7:0]};
            end
            DS_HALF:
            begin
                s_base_be     = be_t'(4'b0011);
                s_data_masked = {16'h0, beat.data[15:0]};
            end
            default:
            begin
                s_base_be     = be_t'(4'b1111);
                s_data_masked = beat.data;
            end
        endcase
    end

    ////////////////////
    // lane placement
    ////////////////////
    // shifting over two words leaves the spilled bytes in the upper half
    assign s_be_wide   = {{BE_W{1'b0}}, s_base_be} << beat.addr[ALIGN_BITS-1:0];
    assign s_data_wide = {{DATA_W{1'b0}}, s_data_masked} << {beat.addr[ALIGN_BITS-1:0], 3'b000};
    assign s_cross     = |s_be_wide[2*BE_W-1:BE_W];

    assign s_word_addr      = {beat.addr[L2_AW-1:ALIGN_BITS], {ALIGN_BITS{1'b0}}};
    assign s_word_addr_next = s_word_addr + l2_addr_t'(BE_W);

    assign l2_req_o   = beat.valid;
    assign l2_addr_o  = {L2_BASE, (r_state == ST_SECOND) ? s_word_addr_next : s_word_addr};
    assign l2_be_o    = (r_state == ST_SECOND) ? s_be_wide[2*BE_W-1:BE_W] : s_be_wide[BE_W-1:0];
    assign l2_wdata_o = (r_state == ST_SECOND) ? s_data_wide[2*DATA_W-1:DATA_W]
                                               : s_data_wide[DATA_W-1:0];

    always_comb
    begin
        s_state_next = r_state;
        beat.ready   = 1'b0;
        case (r_state)
            ST_ALIGNED:
            begin
                if (beat.valid && l2_gnt_i)
                begin
                    if (s_cross)
                        s_state_next = ST_SECOND;   // beat stays at the queue head
                    else
                        beat.ready = 1'b1;
                end
            end
            default:
            begin
                if (beat.valid && l2_gnt_i)
                begin
                    beat.ready   = 1'b1;
                    s_state_next = ST_ALIGNED;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_state <= ST_ALIGNED;
        else
            r_state <= s_state_next;
    end

endmodule

/* logic/udma_rx_top.sv */
// top level of the uDMA linear receive path with plain per-channel and L2 ports
`timescale 1ns/1ps

module udma_rx_top
(
    input  logic                                             clk_i,
    input  logic                                             rstn_i,
    input  logic                        [rx_pkg::N_CH-1:0]   periph_valid_i,
    input  rx_pkg::data_t               [rx_pkg::N_CH-1:0]   periph_data_i,
    input  rx_pkg::datasize_e           [rx_pkg::N_CH-1:0]   periph_size_i,
    output logic                        [rx_pkg::N_CH-1:0]   periph_ready_o,
    input  rx_pkg::l2_addr_t            [rx_pkg::N_CH-1:0]   cfg_startaddr_i,
    input  rx_pkg::trans_size_t         [rx_pkg::N_CH-1:0]   cfg_size_i,
    input  logic                        [rx_pkg::N_CH-1:0]   cfg_continuous_i,
    input  logic                        [rx_pkg::N_CH-1:0]   cfg_en_i,
    input  logic                        [rx_pkg::N_CH-1:0]   cfg_clr_i,
    output logic                        [rx_pkg::N_CH-1:0]   ch_en_o,
    output logic                        [rx_pkg::N_CH-1:0]   event_o,
    output logic                                             l2_req_o,
    input  logic                                             l2_gnt_i,
    output logic                        [31:0]               l2_addr_o,
    output rx_pkg::be_t                                      l2_be_o,
    output rx_pkg::data_t                                    l2_wdata_o
);
    import rx_pkg::*;

    rx_ch_if ch_if [N_CH] ();
    l2_wr_if push_if ();    // sampler to queue
    l2_wr_if pop_if ();     // queue to aligner

    for (genvar g = 0; g < N_CH; g++)
    begin : g_lin_ch
        rx_lin_channel u_lin_ch
        (
            .clk_i            ( clk_i               ),
            .rstn_i           ( rstn_i              ),
            .cfg_startaddr_i  ( cfg_startaddr_i[g]  ),
            .cfg_size_i       ( cfg_size_i[g]       ),
            .cfg_continuous_i ( cfg_continuous_i[g] ),
            .cfg_en_i         ( cfg_en_i[g]         ),
            .cfg_clr_i        ( cfg_clr_i[g]        ),
            .periph_valid_i   ( periph_valid_i[g]   ),
            .periph_data_i    ( periph_data_i[g]    ),
            .periph_size_i    ( periph_size_i[g]    ),
            .periph_ready_o   ( periph_ready_o[g]   ),
            .ch_en_o          ( ch_en_o[g]          ),
            .event_o          ( event_o[g]          ),
            .ch               ( ch_if[g]            )
        );
    end

    rx_sample_stage u_sample
    (
        .clk_i  ( clk_i   ),
        .rstn_i ( rstn_i  ),
        .ch     ( ch_if   ),
        .q      ( push_if )
    );

    rx_wr_queue u_queue
    (
        .clk_i  ( clk_i   ),
        .rstn_i ( rstn_i  ),
        .push   ( push_if ),
        .pop    ( pop_if  )
    );

    rx_l2_aligner u_aligner
    (
        .clk_i      ( clk_i      ),
        .rstn_i     ( rstn_i     ),
        .beat       ( pop_if     ),
        .l2_req_o   ( l2_req_o   ),
        .l2_gnt_i   ( l2_gnt_i   ),
        .l2_addr_o  ( l2_addr_o  ),
        .l2_be_o    ( l2_be_o    ),
        .l2_wdata_o ( l2_wdata_o )
    );

endmodule

/* verification/tb_clkgen.sv */
// clock and reset source for the receive path testbench, 4 ns clock with reset held for two cycles
`timescale 1ns/1ps

module tb_clkgen
(
    output logic clk_o,
    output logic rstn_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial
    begin
        rstn_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;  // released away from the active edge
    end

endmodule

/* verification/rx_checker.sv */
// watches the receive path ports, predicts every L2 write from accepted beats and counts mismatches
`timescale 1ns/1ps

module rx_checker
(
    input  logic                                      clk_i,
    input  logic                                      rstn_i,
    input  logic                [rx_pkg::N_CH-1:0]    periph_valid_i,
    input  rx_pkg::data_t       [rx_pkg::N_CH-1:0]    periph_data_i,
    input  rx_pkg::datasize_e   [rx_pkg::N_CH-1:0]    periph_size_i,
    input  logic                [rx_pkg::N_CH-1:0]    periph_ready_i,
    input  rx_pkg::l2_addr_t    [rx_pkg::N_CH-1:0]    cfg_startaddr_i,
    input  rx_pkg::trans_size_t [rx_pkg::N_CH-1:0]    cfg_size_i,
    input  logic                [rx_pkg::N_CH-1:0]    cfg_continuous_i,
    input  logic                [rx_pkg::N_CH-1:0]    cfg_en_i,
    input  logic                [rx_pkg::N_CH-1:0]    cfg_clr_i,
    input  logic                [rx_pkg::N_CH-1:0]    ch_en_i,
    input  logic                [rx_pkg::N_CH-1:0]    event_i,
    input  logic                                      l2_req_i,
    input  logic                                      l2_gnt_i,
    input  logic                [31:0]                l2_addr_i,
    input  rx_pkg::be_t                               l2_be_i,
    input  rx_pkg::data_t                             l2_wdata_i,
    output int                                        err_value_o,
    output int                                        err_other_o,
    output int                                        pending_o
);
    import rx_pkg::*;

    localparam logic [15:0] EXP_BASE = 16'h1C00;

    logic [67:0] exp_q [N_CH][$];  // {address, byte enables, data} per expected write
    l2_addr_t    m_addr [N_CH];
    trans_size_t m_left [N_CH];
    logic        m_en [N_CH];
    logic        m_event [N_CH];

    function automatic int beat_bytes(input datasize_e size);
        if (size == DS_BYTE)
            return 1;
        else if (size == DS_HALF)
            return 2;
        return 4;
    endfunction

    task automatic compare_value(input int c, input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERR ch%0d %s: got %h expected %h", c, name, got, exp);
            err_value_o++;
        end
    endtask

    ////////////////////
    // expected writes
    ////////////////////
    // each byte i of the beat lands on lane offset+i, lanes past 3 spill into the next word
    task automatic push_expected(input int c, input l2_addr_t addr, input int nb,
                                 input data_t data);
        int          lane;
        logic [3:0]  be0;
        logic [3:0]  be1;
        logic [31:0] d0;
        logic [31:0] d1;
        be0 = '0;
        be1 = '0;
        d0  = '0;
        d1  = '0;
        for (int i = 0; i < nb; i++)
        begin
            lane = int'(addr[1:0]) + i;
            if (lane < 4)
            begin
                be0[lane]         = 1'b1;
                d0[lane*8 +: 8]   = data[i*8 +: 8];
            end
            else
            begin
                be1[lane-4]       = 1'b1;
                d1[(lane-4)*8 +: 8] = data[i*8 +: 8];
            end
        end
        exp_q[c].push_back({EXP_BASE, addr[15:2], 2'b00, be0, d0});
        if (be1 != '0)
            exp_q[c].push_back({EXP_BASE, addr[15:2] + 14'd1, 2'b00, be1, d1});
    endtask

    task automatic check_write();
        int          c;
        logic [67:0] exp;
        c = int'(l2_addr_i[13:12]);   // every channel owns its own 4 KiB window
        if (exp_q[c].size() == 0)
        begin
            $display("unexpected L2 write to %h while channel %0d has no beat pending",
                     l2_addr_i, c);
            err_other_o++;
        end
        else
        begin
            exp = exp_q[c].pop_front();
            compare_value(c, "l2_addr_o", l2_addr_i, exp[67:36]);
            compare_value(c, "l2_be_o", 32'(l2_be_i), 32'(exp[35:32]));
            compare_value(c, "l2_wdata_o", l2_wdata_i, exp[31:0]);
        end
    endtask

    task automatic update_channel(input int c);
        int   nb;
        logic accept;
        accept     = periph_valid_i[c] && periph_ready_i[c];
        nb         = beat_bytes(periph_size_i[c]);
        m_event[c] = 1'b0;
        if (accept)
            push_expected(c, m_addr[c], nb, periph_data_i[c]);
        if (cfg_clr_i[c])
            m_en[c] = 1'b0;
        else if (cfg_en_i[c])
        begin
            m_addr[c] = cfg_startaddr_i[c];
            m_left[c] = cfg_size_i[c];
            m_en[c]   = 1'b1;
        end
        else if (accept)
        begin
            if (int'(m_left[c]) <= nb)
            begin
                m_event[c] = 1'b1;
                if (cfg_continuous_i[c])
                begin
                    m_addr[c] = cfg_startaddr_i[c];
                    m_left[c] = cfg_size_i[c];
                end
                else
                    m_en[c] = 1'b0;
            end
            else
            begin
                m_addr[c] = m_addr[c] + l2_addr_t'(nb);
                m_left[c] = m_left[c] - trans_size_t'(nb);
            end
        end
    endtask

    // registered outputs are compared with the model state left by the previous edge
    always @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int c = 0; c < N_CH; c++)
            begin
                exp_q[c].delete();
                m_addr[c]  = '0;
                m_left[c]  = '0;
                m_en[c]    = 1'b0;
                m_event[c] = 1'b0;
            end
            err_value_o = 0;
            err_other_o = 0;
            pending_o   = 0;
        end
        else
        begin
            for (int c = 0; c < N_CH; c++)
            begin
                compare_value(c, "ch_en_o", 32'(ch_en_i[c]), 32'(m_en[c]));
                compare_value(c, "event_o", 32'(event_i[c]), 32'(m_event[c]));
                if (periph_ready_i[c] && !m_en[c])
                begin
                    $display("channel %0d raised ready while disabled", c);
                    err_other_o++;
                end
            end
            // a queued beat always still has at least one predicted write left
            if (l2_req_i && pending_o == 0)
            begin
                $display("L2 request raised while no write was pending");
                err_other_o++;
            end
            if (l2_req_i && l2_gnt_i)
                check_write();
            pending_o = 0;
            for (int c = 0; c < N_CH; c++)
            begin
                update_channel(c);
                pending_o += exp_q[c].size();
            end
        end
    end

endmodule

/* verification/rx_tb.sv */
// testbench top for the uDMA receive path, drives random beats and L2 grants and reports the result
`timescale 1ns/1ps

module rx_tb;
    import rx_pkg::*;

    localparam int XFER_BYTES  = 40;
    localparam int CONT_BYTES  = 8;
    localparam int LONG_BYTES  = 200;
    // beats are bounded by bytes, the cleared long transfer gets a fixed allowance
    localparam int TOTAL_BEATS = 2 * N_CH * XFER_BYTES + 3 * CONT_BYTES + 64;
    localparam int CYCLE_LIMIT = 40 * TOTAL_BEATS + 200;

    logic                      clk;
    logic                      rstn;
    logic         [N_CH-1:0]   periph_valid;
    data_t        [N_CH-1:0]   periph_data;
    datasize_e    [N_CH-1:0]   periph_size;
    logic         [N_CH-1:0]   periph_ready;
    l2_addr_t     [N_CH-1:0]   cfg_startaddr;
    trans_size_t  [N_CH-1:0]   cfg_size;
    logic         [N_CH-1:0]   cfg_continuous;
    logic         [N_CH-1:0]   cfg_en;
    logic         [N_CH-1:0]   cfg_clr;
    logic         [N_CH-1:0]   ch_en;
    logic         [N_CH-1:0]   ev;
    logic                      l2_req;
    logic                      l2_gnt;
    logic         [31:0]       l2_addr;
    be_t                       l2_be;
    data_t                     l2_wdata;

    int          seed;
    int          cycles;
    int          tb_errors;
    int          err_value;
    int          err_other;
    int          pending;
    int          base1;
    int          base2;
    logic        gnt_hold;
    logic [N_CH-1:0] took = '0;
    int          event_count [N_CH] = '{default: 0};

    tb_clkgen u_clkgen
    (
        .clk_o  ( clk  ),
        .rstn_o ( rstn )
    );

    udma_rx_top u_udma_rx_top
    (
        .clk_i            ( clk            ),
        .rstn_i           ( rstn           ),
        .periph_valid_i   ( periph_valid   ),
        .periph_data_i    ( periph_data    ),
        .periph_size_i    ( periph_size    ),
        .periph_ready_o   ( periph_ready   ),
        .cfg_startaddr_i  ( cfg_startaddr  ),
        .cfg_size_i       ( cfg_size       ),
        .cfg_continuous_i ( cfg_continuous ),
        .cfg_en_i         ( cfg_en         ),
        .cfg_clr_i        ( cfg_clr        ),
        .ch_en_o          ( ch_en          ),
        .event_o          ( ev             ),
        .l2_req_o         ( l2_req         ),
        .l2_gnt_i         ( l2_gnt         ),
        .l2_addr_o        ( l2_addr        ),
        .l2_be_o          ( l2_be          ),
        .l2_wdata_o       ( l2_wdata       )
    );

    rx_checker u_checker
    (
        .clk_i            ( clk            ),
        .rstn_i           ( rstn           ),
        .periph_valid_i   ( periph_valid   ),
        .periph_data_i    ( periph_data    ),
        .periph_size_i    ( periph_size    ),
        .periph_ready_i   ( periph_ready   ),
        .cfg_startaddr_i  ( cfg_startaddr  ),
        .cfg_size_i       ( cfg_size       ),
        .cfg_continuous_i ( cfg_continuous ),
        .cfg_en_i         ( cfg_en         ),
        .cfg_clr_i        ( cfg_clr        ),
        .ch_en_i          ( ch_en          ),
        .event_i          ( ev             ),
        .l2_req_i         ( l2_req         ),
        .l2_gnt_i         ( l2_gnt         ),
        .l2_addr_i        ( l2_addr        ),
        .l2_be_i          ( l2_be          ),
        .l2_wdata_i       ( l2_wdata       ),
        .err_value_o      ( err_value      ),
        .err_other_o      ( err_other      ),
        .pending_o        ( pending        )
    );

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // each channel writes into its own 4 KiB window at a random byte offset
    task automatic start_channel(input int c, input logic cont, input int nbytes);
        int offset;
        @(posedge clk);
        offset = rand_below(4);
        @(negedge clk);
        cfg_startaddr[c]  = l2_addr_t'(c * 32'h1000 + offset);
        cfg_size[c]       = trans_size_t'(nbytes);
        cfg_continuous[c] = cont;
        cfg_en[c]         = 1'b1;
        @(negedge clk);
        cfg_en[c]         = 1'b0;
    endtask

    // idle needs a few quiet cycles since a beat can sit in the sample register
    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 4)
        begin
            @(negedge clk);
            if (ch_en == '0 && !l2_req)
                quiet++;
            else
                quiet = 0;
        end
    endtask

    always @(posedge clk)
    begin
        took <= periph_valid & periph_ready;
        for (int c = 0; c < N_CH; c++)
            if (ev[c])
                event_count[c] <= event_count[c] + 1;
    end

    ////////////////////
    // stimulus
    ////////////////////
    initial
    begin : drive_beats
        seed         = 69881;
        periph_valid = '0;
        periph_data  = '0;
        periph_size  = '{default: DS_BYTE};
        l2_gnt       = 1'b0;
        forever
        begin
            @(negedge clk);
            for (int c = 0; c < N_CH; c++)
            begin
                if (!(periph_valid[c] && !took[c]))   // an offered beat waits until taken
                begin
                    periph_valid[c] = (rand_below(10) < 6);
                    periph_data[c]  = $random(seed);
                    periph_size[c]  = datasize_e'(2'(rand_below(3)));
                end
            end
            l2_gnt = !gnt_hold && (rand_below(10) < 6);
        end
    end

    initial
    begin : run_tests
        tb_errors      = 0;
        gnt_hold       = 1'b0;
        cfg_startaddr  = '0;
        cfg_size       = '0;
        cfg_continuous = '0;
        cfg_en         = '0;
        cfg_clr        = '0;
        wait (rstn === 1'b1);

        for (int c = 0; c < N_CH; c++)
            start_channel(c, 1'b0, XFER_BYTES);
        wait_idle();

        gnt_hold <= 1'b1;   // queue fills and back-pressures the channels
        for (int c = 0; c < N_CH; c++)
            start_channel(c, 1'b0, XFER_BYTES);
        repeat (30) @(negedge clk);
        gnt_hold <= 1'b0;
        wait_idle();

        base1 = event_count[1];
        base2 = event_count[2];
        start_channel(1, 1'b1, CONT_BYTES);
        start_channel(2, 1'b0, LONG_BYTES);
        while (event_count[1] < base1 + 3)
            @(negedge clk);
        if (!ch_en[1] || !ch_en[2])
        begin
            $display("a channel stopped before the clear pulse");
            tb_errors++;
        end
        cfg_clr[1] = 1'b1;
        cfg_clr[2] = 1'b1;
        @(negedge clk);
        cfg_clr           = '0;
        cfg_continuous[1] = 1'b0;
        wait_idle();
        if (event_count[2] != base2)
        begin
            $display("channel 2 signalled an end of transfer although it was cleared");
            tb_errors++;
        end

        if (pending != 0)
        begin
            $display("%0d expected L2 writes never appeared", pending);
            tb_errors++;
        end
        $display("errors: %0d value, %0d protocol, %0d testbench", err_value, err_other,
                 tb_errors);
        if (err_value + err_other + tb_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* sim.f */
logic/rx_pkg.sv
logic/rx_ch_if.sv
logic/l2_wr_if.sv
logic/rx_lin_channel.sv
logic/rx_rr_arbiter.sv
logic/rx_sample_stage.sv
logic/rx_wr_queue.sv
logic/rx_l2_aligner.sv
logic/udma_rx_top.sv
verification/tb_clkgen.sv
verification/rx_checker.sv
verification/rx_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rx_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
